// ==== source/access_ctrl.sv ====
`timescale 1ns/10ps

module access_ctrl import mem_arb_pkg::*, mem_ctrl_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    // Arbitration
    input  logic [N_CLIENTS-1:0] pending,
    output logic [N_CLIENTS-1:0] arb_req,
    input  logic [N_CLIENTS-1:0] gnt,
    output logic [N_CLIENTS-1:0] cur_sel,
    // Winning request
    input  logic [ADDR_W-1:0]    sel_addr,
    input  logic                 sel_write,
    input  logic [DATA_W-1:0]    sel_wdata,
    // Memory side
    output logic                 ram_en,
    output logic                 ram_we,
    output logic [MEM_AW-1:0]    ram_addr,
    output logic [DATA_W-1:0]    ram_wdata,
    input  logic [DATA_W-1:0]    ram_rdata,
    // Response
    output logic                 done,
    output logic                 resp_err,
    output logic [DATA_W-1:0]    resp_rdata
);

    // ====================
    // Declarations
    // ====================

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    access_op_t  op;
    // Opcode and range result captured during the access cycle
    access_op_t  acc_op;
    logic        acc_err;
    logic        in_range;

    // ====================
    // FSM
    // ====================

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    // One cycle per state, no waiting outside idle
    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:   if (|pending) state_nxt = ST_ARB;
            ST_ARB:    state_nxt = ST_ACCESS;
            ST_ACCESS: state_nxt = ST_RESP;
            ST_RESP:   state_nxt = ST_IDLE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    // Requests reach the arbiter only in idle, one grant per transaction
    assign arb_req = (state == ST_IDLE) ? pending : '0;

    // Winner is held until the next arbitration
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            cur_sel <= '0;
        else if (state == ST_ARB)
            cur_sel <= gnt;
    end

    // ====================
    // Decode and range check
    // ====================

    assign op = sel_write ? OP_WRITE : OP_READ;
    assign in_range = (sel_addr < ADDR_W'(MEM_DEPTH));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            acc_op <= OP_READ;
            acc_err <= 1'b0;
        end
        else if (state == ST_ACCESS)
        begin
            acc_op <= op;
            acc_err <= !in_range;
        end
    end

    // ====================
    // Memory access
    // ====================

    // Out of range accesses never touch the array
    assign ram_en = (state == ST_ACCESS) && in_range;
    assign ram_we = ram_en && (op == OP_WRITE);
    assign ram_addr = sel_addr[MEM_AW-1:0];
    assign ram_wdata = sel_wdata;

    // ====================
    // Response
    // ====================

    assign done = (state == ST_RESP);
    assign resp_err = done && acc_err;
    // Zero data for writes and for errors
    assign resp_rdata = (done && !acc_err && (acc_op == OP_READ)) ? ram_rdata : '0;

endmodule : access_ctrl

// ==== source/apb_port_bank.sv ====
`timescale 1ns/10ps

module apb_port_bank import mem_arb_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    // APB slave side, one slice per client
    input  logic [N_CLIENTS-1:0]          psel,
    input  logic [N_CLIENTS-1:0]          penable,
    input  logic [N_CLIENTS-1:0]          pwrite,
    input  logic [N_CLIENTS*ADDR_W-1:0]   paddr,
    input  logic [N_CLIENTS*DATA_W-1:0]   pwdata,
    output logic [N_CLIENTS-1:0]          pready,
    output logic [N_CLIENTS-1:0]          pslverr,
    output logic [N_CLIENTS*DATA_W-1:0]   prdata,
    // Towards the control FSM
    output logic [N_CLIENTS-1:0]          pending,
    input  logic [N_CLIENTS-1:0]          cur_sel,
    output logic [ADDR_W-1:0]             sel_addr,
    output logic                          sel_write,
    output logic [DATA_W-1:0]             sel_wdata,
    input  logic                          done,
    input  logic                          resp_err,
    input  logic [DATA_W-1:0]             resp_rdata
);

    // ====================
    // Pending detection
    // ====================

    // Set when a port is answered, kept until its access phase ends
    logic [N_CLIENTS-1:0] answered;
    logic [N_CLIENTS-1:0] resp_hit;
    logic [CLIENT_W-1:0]  sel_idx;

    // Response goes only to the selected port
    assign resp_hit = done ? cur_sel : '0;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            answered <= '0;
        else
            answered <= (answered | resp_hit) & penable;
    end

    // Access phase seen and not yet served
    assign pending = psel & penable & ~answered;

    // ====================
    // Request mux
    // ====================

    // One-hot select to a client index
    always_comb
    begin
        sel_idx = '0;
        for (int i = 0; i < N_CLIENTS; i++)
        begin
            if (cur_sel[i])
                sel_idx = i[CLIENT_W-1:0];
        end
    end

    assign sel_addr = paddr[sel_idx*ADDR_W +: ADDR_W];
    assign sel_write = pwrite[sel_idx];
    assign sel_wdata = pwdata[sel_idx*DATA_W +: DATA_W];

    // ====================
    // Response fan-out
    // ====================

    // pready and pslverr appear in the same cycle as prdata
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pready <= '0;
            pslverr <= '0;
        end
        else
        begin
            pready <= resp_hit;
            pslverr <= resp_err ? resp_hit : '0;
        end
    end

    // Read data, loaded only for the answered port
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < N_CLIENTS; i++)
        begin
            if (resp_hit[i])
                prdata[i*DATA_W +: DATA_W] <= resp_rdata;
        end
    end

endmodule : apb_port_bank

// ==== source/mem_arb_pkg.sv ====
package mem_arb_pkg;

    // ====================
    // Port side sizes
    // ====================

    // Number of APB requesters sharing the memory
    localparam int N_CLIENTS = 4;

    // Width of a client index
    localparam int CLIENT_W = 2;

    // APB word address width
    localparam int ADDR_W = 8;

    // APB data width
    localparam int DATA_W = 32;

    // ====================
    // Memory sizes
    // ====================

    // Implemented words, addresses at or above this are out of range
    localparam int MEM_DEPTH = 48;

    // RAM index width
    localparam int MEM_AW = 6;

endpackage : mem_arb_pkg

// ==== source/mem_ctrl_pkg.sv ====
package mem_ctrl_pkg;

    // ====================
    // Control FSM
    // ====================

    // One transaction walks through all four states in order
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ARB,
        ST_ACCESS,
        ST_RESP
    } ctrl_state_t;

    // ====================
    // Access opcode
    // ====================

    // Decoded from the pwrite of the winning port
    typedef enum logic {
        OP_READ,
        OP_WRITE
    } access_op_t;

endpackage : mem_ctrl_pkg

// ==== source/round_robin_arbiter.sv ====
`timescale 1ns/10ps

module round_robin_arbiter #(
    parameter int CLIENTS = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [CLIENTS-1:0] req,
    output logic [CLIENTS-1:0] gnt
);

    // ====================
    // Declarations
    // ====================

    localparam int N = $clog2(CLIENTS);

    // Bits strictly below the last winner
    logic [CLIENTS-1:0] mask;
    // Everything except the last winner
    logic [CLIENTS-1:0] last_win_mask;

    logic [CLIENTS-1:0] req_masked;
    logic [CLIENTS-1:0] req_wrap;
    logic               multi_req;

    logic               vld_req;
    logic               vld_reqm;
    logic [N-1:0]       req_loc;
    logic [N-1:0]       reqm_loc;

    logic [N-1:0]       winner;
    logic               win_vld;
    logic [CLIENTS-1:0] win_onehot;

    // ====================
    // Search
    // ====================

    // More than one bit set when clearing the lowest one leaves something
    assign multi_req = |(req & (req - 1'b1));

    assign req_masked = req & mask;
    // A lone requester may win twice in a row
    assign req_wrap = multi_req ? (req & last_win_mask) : req;

    assign {vld_reqm, reqm_loc} = find_high(req_masked);
    assign {vld_req, req_loc} = find_high(req_wrap);

    // Lower requesters first, otherwise start over from the top
    always_comb
    begin
        win_vld = vld_reqm | vld_req;
        if (vld_reqm)
            winner = reqm_loc;
        else
            winner = req_loc;
    end

    assign win_onehot = {{(CLIENTS-1){1'b0}}, 1'b1} << winner;

    // ====================
    // Registers
    // ====================

    // Masks hold across idle cycles so rotation stays fair
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mask <= '0;
            last_win_mask <= '1;
        end
        else if (win_vld)
        begin
            mask <= win_onehot - 1'b1;
            last_win_mask <= ~win_onehot;
        end
    end

    // One-hot grant, one cycle after the request
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            gnt <= '0;
        else if (win_vld)
            gnt <= win_onehot;
        else
            gnt <= '0;
    end

    // Highest set bit, returned as {valid, index}
    function automatic logic [N:0] find_high(input logic [CLIENTS-1:0] vec);
        logic         vld;
        logic [N-1:0] loc;
        vld = 1'b0;
        loc = '0;
        for (int i = 0; i < CLIENTS; i++)
        begin
            if (vec[i])
            begin
                vld = 1'b1;
                loc = i[N-1:0];
            end
        end
        return {vld, loc};
    endfunction

endmodule : round_robin_arbiter

// ==== source/shared_mem_top.sv ====
`timescale 1ns/10ps

module shared_mem_top import mem_arb_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    // Flattened APB ports, slice i belongs to client i
    input  logic [N_CLIENTS-1:0]        psel,
    input  logic [N_CLIENTS-1:0]        penable,
    input  logic [N_CLIENTS-1:0]        pwrite,
    input  logic [N_CLIENTS*ADDR_W-1:0] paddr,
    input  logic [N_CLIENTS*DATA_W-1:0] pwdata,
    output logic [N_CLIENTS-1:0]        pready,
    output logic [N_CLIENTS-1:0]        pslverr,
    output logic [N_CLIENTS*DATA_W-1:0] prdata
);

    // ====================
    // Internal wiring
    // ====================

    // Arbitration path
    logic [N_CLIENTS-1:0] pending;
    logic [N_CLIENTS-1:0] arb_req;
    logic [N_CLIENTS-1:0] gnt;
    logic [N_CLIENTS-1:0] cur_sel;

    // Selected request
    logic [ADDR_W-1:0]    sel_addr;
    logic                 sel_write;
    logic [DATA_W-1:0]    sel_wdata;

    // Memory bus
    logic                 ram_en;
    logic                 ram_we;
    logic [MEM_AW-1:0]    ram_addr;
    logic [DATA_W-1:0]    ram_wdata;
    logic [DATA_W-1:0]    ram_rdata;

    // Response
    logic                 done;
    logic                 resp_err;
    logic [DATA_W-1:0]    resp_rdata;

    // ====================
    // Instances
    // ====================

    apb_port_bank u_apb_port_bank (
        .clk        (clk),        .rst_n      (rst_n),
        .psel       (psel),       .penable    (penable),
        .pwrite     (pwrite),     .paddr      (paddr),
        .pwdata     (pwdata),     .pready     (pready),
        .pslverr    (pslverr),    .prdata     (prdata),
        .pending    (pending),    .cur_sel    (cur_sel),
        .sel_addr   (sel_addr),   .sel_write  (sel_write),
        .sel_wdata  (sel_wdata),  .done       (done),
        .resp_err   (resp_err),   .resp_rdata (resp_rdata)
    );

    round_robin_arbiter #(
        .CLIENTS (N_CLIENTS)
    ) u_round_robin_arbiter (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (arb_req),
        .gnt   (gnt)
    );

    access_ctrl u_access_ctrl (
        .clk        (clk),        .rst_n      (rst_n),
        .pending    (pending),    .arb_req    (arb_req),
        .gnt        (gnt),        .cur_sel    (cur_sel),
        .sel_addr   (sel_addr),   .sel_write  (sel_write),
        .sel_wdata  (sel_wdata),  .ram_en     (ram_en),
        .ram_we     (ram_we),     .ram_addr   (ram_addr),
        .ram_wdata  (ram_wdata),  .ram_rdata  (ram_rdata),
        .done       (done),       .resp_err   (resp_err),
        .resp_rdata (resp_rdata)
    );

    shared_ram u_shared_ram (
        .clk       (clk),
        .rst_n     (rst_n),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

endmodule : shared_mem_top

// ==== source/shared_ram.sv ====
`timescale 1ns/10ps

module shared_ram import mem_arb_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ram_en,
    input  logic              ram_we,
    input  logic [MEM_AW-1:0] ram_addr,
    input  logic [DATA_W-1:0] ram_wdata,
    output logic [DATA_W-1:0] ram_rdata
);

    // ====================
    // Storage
    // ====================

    logic [DATA_W-1:0] mem [MEM_DEPTH];

    // Array and read register start out zero
    // Read returns the contents from before a same-cycle write
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < MEM_DEPTH; i++)
            begin
                mem[i] <= '0;
            end
            ram_rdata <= '0;
        end
        else if (ram_en)
        begin
            if (ram_we)
                mem[ram_addr] <= ram_wdata;
            // Data shows up one cycle after the address
            ram_rdata <= mem[ram_addr];
        end
    end

endmodule : shared_ram

// ==== tests/tb_shared_mem.sv ====
`timescale 1ns/10ps

module tb_shared_mem import mem_arb_pkg::*; ();

    // ====================
    // Constants
    // ====================

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY = 2;
    localparam int WAIT_LIMIT = 64;
    localparam int SEED = 32'h6349;
    // Words owned by each client
    localparam int QUARTER = MEM_DEPTH / N_CLIENTS;
    // Edge with penable high to the edge that raises pready
    localparam int SOLO_LAT = 3;
    localparam int TOP_ADDR = (1 << ADDR_W) - 1;

    // Client behaviors
    localparam int MODE_READ_ALL = 0;
    localparam int MODE_ONE = 1;
    localparam int MODE_RANDOM = 2;
    localparam int RANDOM_OPS = 150;

    // ====================
    // Signals and model
    // ====================

    logic                        clk;
    logic                        rst_n;
    logic [N_CLIENTS-1:0]        psel;
    logic [N_CLIENTS-1:0]        penable;
    logic [N_CLIENTS-1:0]        pwrite;
    logic [N_CLIENTS*ADDR_W-1:0] paddr;
    logic [N_CLIENTS*DATA_W-1:0] pwdata;
    logic [N_CLIENTS-1:0]        pready;
    logic [N_CLIENTS-1:0]        pslverr;
    logic [N_CLIENTS*DATA_W-1:0] prdata;

    int cyc = 0;
    int err_cnt;
    int check_cnt;
    // Errors seen by the response monitor alone
    int mon_err_cnt;
    // Last winner of the priority rule, -1 before any grant
    int last_win;
    int done_order[$];
    logic [DATA_W-1:0] model_mem [MEM_DEPTH];

    shared_mem_top u_shared_mem_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pready  (pready),
        .pslverr (pslverr),
        .prdata  (prdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Cycle counter for latency measurement
    always @(posedge clk)
        cyc <= cyc + 1;

    // ====================
    // Response monitor
    // ====================

    // Mid-cycle, outputs are settled
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            assert ($countones(pready) <= 1)
            else
            begin
                $display("More than one pready high at %0t, pready %b", $time, pready);
                err_cnt++;
                mon_err_cnt++;
            end
            for (int i = 0; i < N_CLIENTS; i++)
            begin
                assert (!pready[i] || (psel[i] && penable[i]))
                else
                begin
                    $display("Port %0d got pready outside its access phase at %0t", i, $time);
                    err_cnt++;
                    mon_err_cnt++;
                end
            end
        end
    end

    // ====================
    // Helpers
    // ====================

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        check_cnt++;
        assert (got === exp)
        else
        begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before)
            $display("Test %s: ok", name);
        else
            $display("Test %s: %0d errors", name, err_cnt - errs_before);
    endtask

    // Own quarter, or now and then a word past the memory
    function automatic logic [ADDR_W-1:0] pick_addr(input int port, input bit allow_oor);
        int a;
        if (allow_oor && ($urandom_range(7, 0) == 0))
            a = $urandom_range(TOP_ADDR, MEM_DEPTH);
        else
            a = port * QUARTER + $urandom_range(QUARTER - 1, 0);
        return a[ADDR_W-1:0];
    endfunction

    // Next winner after last, given the pending set
    function automatic int pick_next(input logic [N_CLIENTS-1:0] pend, input int last);
        int win;
        win = -1;
        // Highest pending client below the last winner
        for (int i = 0; i < N_CLIENTS; i++)
            if (pend[i] && (i < last))
                win = i;
        // Else from the top, the last winner only when it is alone
        if (win < 0)
        begin
            for (int i = 0; i < N_CLIENTS; i++)
                if (pend[i] && ((i != last) || ($countones(pend) == 1)))
                    win = i;
        end
        return win;
    endfunction

    // One APB transfer on one port, setup then access until pready
    task automatic apb_xfer(input int port, input bit wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata,
                            output logic slverr, output int lat, output bit ok);
        int start_cyc;
        int waited;
        rdata = '0;
        slverr = 1'b0;
        lat = 0;
        ok = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;
        psel[port] = 1'b1;
        penable[port] = 1'b0;
        pwrite[port] = wr;
        paddr[port*ADDR_W +: ADDR_W] = addr;
        pwdata[port*DATA_W +: DATA_W] = wdata;
        @(posedge clk);
        #DRIVE_DLY;
        penable[port] = 1'b1;
        // Next edge is the first one with psel and penable both high
        start_cyc = cyc + 1;
        waited = 0;
        while (!ok && (waited < WAIT_LIMIT))
        begin
            @(negedge clk);
            if (pready[port])
            begin
                ok = 1'b1;
                rdata = prdata[port*DATA_W +: DATA_W];
                slverr = pslverr[port];
                lat = cyc - start_cyc;
            end
            waited++;
        end
        @(posedge clk);
        #DRIVE_DLY;
        psel[port] = 1'b0;
        penable[port] = 1'b0;
    endtask

    // Transfer plus comparison against the model
    task automatic do_access(input int port, input bit wr, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] wdata, input bit check_lat);
        logic [DATA_W-1:0] rdata;
        logic              slverr;
        int                lat;
        bit                ok;
        bit                oor;
        oor = (addr >= MEM_DEPTH);
        apb_xfer(port, wr, addr, wdata, rdata, slverr, lat, ok);
        check_cnt++;
        assert (ok)
        else
        begin
            $display("Port %0d saw no pready within %0d cycles", port, WAIT_LIMIT);
            err_cnt++;
        end
        if (ok)
        begin
            check_value($sformatf("pslverr[%0d]", port), slverr, oor);
            if (oor)
                check_value($sformatf("prdata[%0d]", port), rdata, '0);
            else if (!wr)
                check_value($sformatf("prdata[%0d]", port), rdata, model_mem[addr]);
            else
                model_mem[addr] = wdata;
            if (check_lat)
                check_value($sformatf("pready[%0d] latency", port), lat, SOLO_LAT);
            done_order.push_back(port);
        end
    endtask

    task automatic client(input int port, input int mode);
        case (mode)
            MODE_READ_ALL:
            begin
                for (int w = 0; w < QUARTER; w++)
                    do_access(port, 1'b0, port * QUARTER + w, '0, 1'b0);
            end
            MODE_ONE:
                do_access(port, $urandom_range(1, 0), pick_addr(port, 1'b0), $urandom, 1'b0);
            default:
            begin
                for (int k = 0; k < RANDOM_OPS; k++)
                begin
                    // Idle gap of a few cycles
                    repeat ($urandom_range(3, 0)) @(posedge clk);
                    do_access(port, $urandom_range(1, 0), pick_addr(port, 1'b1), $urandom,
                              1'b0);
                end
            end
        endcase
    endtask

    // All four clients start on the same edge
    task automatic run_clients(input int mode);
        fork
            client(0, mode);
            client(1, mode);
            client(2, mode);
            client(3, mode);
        join
    endtask

    // ====================
    // Test sequence
    // ====================

    initial
    begin
        int                   expected[$];
        logic [N_CLIENTS-1:0] pend;
        logic [ADDR_W-1:0]    a;
        int                   l;
        int                   w;
        int                   errs;
        void'($urandom(SEED));
        rst_n = 1'b0;
        psel = '0;
        penable = '0;
        pwrite = '0;
        paddr = '0;
        pwdata = '0;
        err_cnt = 0;
        check_cnt = 0;
        mon_err_cnt = 0;
        last_win = -1;
        for (int i = 0; i < MEM_DEPTH; i++)
            model_mem[i] = '0;

        // Reset state, outputs quiet and memory cleared
        errs = err_cnt;
        repeat (3)
        begin
            @(posedge clk);
            #1;
            check_value("pready", pready, '0);
            check_value("pslverr", pslverr, '0);
        end
        #(DRIVE_DLY - 1) rst_n = 1'b1;
        @(negedge clk);
        check_value("pready", pready, '0);
        check_value("pslverr", pslverr, '0);
        run_clients(MODE_READ_ALL);
        report_test("reset state", errs);

        // Each port alone, write then read back
        errs = err_cnt;
        for (int p = 0; p < N_CLIENTS; p++)
        begin
            for (int k = 0; k < 2; k++)
            begin
                a = pick_addr(p, 1'b0);
                do_access(p, 1'b1, a, $urandom, 1'b1);
                do_access(p, 1'b0, a, '0, 1'b1);
            end
        end
        report_test("single port write and read", errs);

        // Past the implemented depth
        errs = err_cnt;
        for (int p = 0; p < N_CLIENTS; p++)
        begin
            a = $urandom_range(TOP_ADDR, MEM_DEPTH);
            do_access(p, 1'b1, a, $urandom, 1'b0);
            do_access(p, 1'b0, a, '0, 1'b0);
        end
        run_clients(MODE_READ_ALL);
        report_test("out of range access", errs);

        // Everyone requests at once, order follows the rotation
        errs = err_cnt;
        // A lone request leaves port 1 as the known last winner
        do_access(1, 1'b0, pick_addr(1, 1'b0), '0, 1'b0);
        last_win = 1;
        for (int r = 0; r < 8; r++)
        begin
            expected.delete();
            done_order.delete();
            pend = '1;
            l = last_win;
            for (int j = 0; j < N_CLIENTS; j++)
            begin
                w = pick_next(pend, l);
                expected.push_back(w);
                pend[w] = 1'b0;
                l = w;
            end
            last_win = l;
            run_clients(MODE_ONE);
            check_value("completed transfers", done_order.size(), N_CLIENTS);
            for (int j = 0; j < done_order.size(); j++)
                check_value($sformatf("pready order slot %0d", j), done_order[j], expected[j]);
        end
        report_test("round robin order", errs);

        // Mixed traffic on all ports
        errs = err_cnt;
        run_clients(MODE_RANDOM);
        report_test("random concurrent traffic", errs);

        // Monitor findings over the whole run
        errs = err_cnt - mon_err_cnt;
        report_test("response integrity", errs);

        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule : tb_shared_mem

// ==== vlog.f ====
source/mem_arb_pkg.sv
source/mem_ctrl_pkg.sv
source/round_robin_arbiter.sv
source/apb_port_bank.sv
source/access_ctrl.sv
source/shared_ram.sv
source/shared_mem_top.sv
tests/tb_shared_mem.sv
